// File: logic/rvv_isa_pkg.sv
/* RVV encodings for the decoded subset only: integer OP-V, unit and strided
   memory access, vsetvl. OPM, floating point and CSR codes are absent */
`default_nettype none

package rvv_isa_pkg;

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP_V     = 7'b1010111;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

  // OP-V operand category in funct3
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPCFG = 3'b111
  } funct3_e;

  //////////////////////////////////////////////////
  // funct6 codes of the integer OP-V group
  //////////////////////////////////////////////////

  localparam logic [5:0] F6_VADD       = 6'b000000;
  localparam logic [5:0] F6_VSUB       = 6'b000010;
  localparam logic [5:0] F6_VRSUB      = 6'b000011;
  localparam logic [5:0] F6_VAND       = 6'b001001;
  localparam logic [5:0] F6_VOR        = 6'b001010;
  localparam logic [5:0] F6_VXOR       = 6'b001011;
  localparam logic [5:0] F6_VSLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_VSLIDEDOWN = 6'b001111;
  // Shared with vmerge, which needs vm 0
  localparam logic [5:0] F6_VMV        = 6'b010111;
  localparam logic [5:0] F6_VSLL       = 6'b100101;
  localparam logic [5:0] F6_VSRL       = 6'b101000;
  localparam logic [5:0] F6_VSRA       = 6'b101001;

  //////////////////////////////////////////////////
  // Memory access
  //////////////////////////////////////////////////

  // Addressing mode, bits 27:26
  localparam logic [1:0] MOP_UNIT    = 2'b00;
  localparam logic [1:0] MOP_STRIDED = 2'b10;

  // Selected element width
  typedef enum logic [2:0] {
    EW_8  = 3'b000,
    EW_16 = 3'b001,
    EW_32 = 3'b010
  } vsew_e;

endpackage : rvv_isa_pkg

`default_nettype wire

// File: logic/vdec_pkg.sv
/* Decoder request and response types. ELEN is fixed at 32 bits and
   vtype.vill is never set by the decoder */
`default_nettype none

package vdec_pkg;

  localparam int unsigned ELEN       = 32;
  localparam int unsigned XINTF_ID_W = 4;

  typedef logic [ELEN-1:0] elen_t;
  typedef logic [4:0]      vreg_t;

  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    logic [2:0] vsew;
    logic [2:0] vlmul;
  } vtype_t;

  typedef enum logic [3:0] {
    VLE, VLSE, VSE, VSSE,
    VADD, VSUB, VRSUB,
    VAND, VOR, VXOR,
    VSLL, VSRL, VSRA,
    VSLIDEUP, VSLIDEDOWN,
    VCFG
  } op_e;

  // Execution unit that takes the request
  typedef enum logic [1:0] {
    CON, VFU, LSU, SLD
  } ex_unit_e;

  //////////////////////////////////////////////////
  // Interface structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0]           instr;
    elen_t                 rs1;
    logic                  rs1_valid;
    elen_t                 rs2;
    logic                  rs2_valid;
    logic [XINTF_ID_W-1:0] xintf_id;
  } vdec_req_t;

  typedef struct packed {
    op_e                   op;
    ex_unit_e              ex_unit;
    vreg_t                 vd;
    vreg_t                 vs1;
    vreg_t                 vs2;
    vreg_t                 rd;
    logic                  use_vd;
    logic                  use_vs1;
    logic                  use_vs2;
    logic                  use_rd;
    logic                  vd_is_src;
    elen_t                 rs1;
    elen_t                 rs2;
    vtype_t                vtype;
    logic                  is_load;
    logic                  vm;
    // Slide unit controls
    logic                  insert;
    logic                  vmv;
    logic                  keep_vl;
    logic                  reset_vstart;
    logic [XINTF_ID_W-1:0] xintf_id;
  } vec_req_t;

  // One sub-decoder's view, all zero without a hit
  typedef struct packed {
    logic     hit;
    logic     illegal;
    vec_req_t req;
  } vdec_part_t;

  typedef struct packed {
    vec_req_t req;
    logic     illegal;
  } vdec_rsp_t;

endpackage : vdec_pkg

`default_nettype wire

// File: logic/vdec_mem_decode.sv
/* Unit-stride and strided loads and stores, EEW 8/16/32 only.
   The nf field is not checked */
`default_nettype none

module vdec_mem_decode (
  input  vdec_pkg::vdec_req_t  req_i,
  output vdec_pkg::vdec_part_t part_o
);

  import vdec_pkg::*;
  import rvv_isa_pkg::*;

  logic       hit;
  logic       is_store;
  logic       strided;
  logic [3:0] ew_code;
  logic [1:0] mop;
  logic       ew_bad;
  logic       mop_bad;

  assign is_store = (req_i.instr[6:0] == OPC_STORE_FP);
  assign hit      = (req_i.instr[6:0] == OPC_LOAD_FP) | is_store;
  assign ew_code  = {req_i.instr[28], req_i.instr[14:12]};
  assign mop      = req_i.instr[27:26];
  assign strided  = (mop == MOP_STRIDED);
  assign mop_bad  = (mop != MOP_UNIT) & ~strided;

  always_comb begin
    part_o = '0;
    ew_bad = 1'b0;
    if (hit) begin
      part_o.hit           = 1'b1;
      part_o.req.ex_unit   = LSU;
      part_o.req.vd        = req_i.instr[11:7];
      part_o.req.use_vd    = 1'b1;
      part_o.req.vm        = req_i.instr[25];
      part_o.req.is_load   = ~is_store;
      // Stores read vd as data source
      part_o.req.vd_is_src = is_store;
      part_o.req.rs1       = req_i.rs1;

      unique case (ew_code)
        4'b0000: part_o.req.vtype.vsew = EW_8;
        4'b0101: part_o.req.vtype.vsew = EW_16;
        4'b0110: part_o.req.vtype.vsew = EW_32;
        default: ew_bad = 1'b1;
      endcase

      if (strided) begin
        part_o.req.rs2 = req_i.rs2;
        part_o.req.op  = is_store ? VSSE : VLSE;
      end else begin
        part_o.req.op  = is_store ? VSE : VLE;
      end

      part_o.illegal = ew_bad | mop_bad | ~req_i.rs1_valid | (strided & ~req_i.rs2_valid);
    end
  end

endmodule : vdec_mem_decode

`default_nettype wire

// File: logic/vdec_arith_decode.sv
/* Integer OP-V in VV, VX and VI forms, slides and vmv.v. OPM forms fall
   into this group and come out illegal */
`default_nettype none

module vdec_arith_decode (
  input  vdec_pkg::vdec_req_t  req_i,
  output vdec_pkg::vdec_part_t part_o
);

  import vdec_pkg::*;
  import rvv_isa_pkg::*;

  logic       hit;
  funct3_e    funct3;
  logic [5:0] funct6;
  logic [4:0] fld_vs1;
  logic       vm;
  logic       imm_zext;
  logic       op_bad;
  logic       opnd_bad;

  assign funct3  = funct3_e'(req_i.instr[14:12]);
  assign funct6  = req_i.instr[31:26];
  assign fld_vs1 = req_i.instr[19:15];
  assign vm      = req_i.instr[25];
  assign hit     = (req_i.instr[6:0] == OPC_OP_V) & (funct3 != OPCFG);

  always_comb begin
    part_o   = '0;
    imm_zext = 1'b0;
    op_bad   = 1'b0;
    opnd_bad = 1'b0;
    if (hit) begin
      part_o.hit         = 1'b1;
      part_o.req.ex_unit = VFU;
      part_o.req.vd      = req_i.instr[11:7];
      part_o.req.use_vd  = 1'b1;
      part_o.req.vs2     = req_i.instr[24:20];
      part_o.req.use_vs2 = 1'b1;
      part_o.req.vm      = vm;

      //////////////////////////////////////////////////
      // Operation
      //////////////////////////////////////////////////
      unique case (funct6)
        F6_VADD: part_o.req.op = VADD;
        F6_VSUB: begin
          part_o.req.op = VSUB;
          op_bad        = (funct3 == OPIVI);
        end
        F6_VRSUB: begin
          part_o.req.op = VRSUB;
          op_bad        = (funct3 == OPIVV);
        end
        F6_VAND: part_o.req.op = VAND;
        F6_VOR:  part_o.req.op = VOR;
        F6_VXOR: part_o.req.op = VXOR;
        F6_VSLL: begin
          part_o.req.op = VSLL;
          imm_zext      = 1'b1;
        end
        F6_VSRL: begin
          part_o.req.op = VSRL;
          imm_zext      = 1'b1;
        end
        F6_VSRA: begin
          part_o.req.op = VSRA;
          imm_zext      = 1'b1;
        end
        F6_VSLIDEUP, F6_VSLIDEDOWN: begin
          part_o.req.op      = (funct6 == F6_VSLIDEUP) ? VSLIDEUP : VSLIDEDOWN;
          part_o.req.ex_unit = SLD;
          imm_zext           = 1'b1;
          op_bad             = (funct3 == OPIVV);
        end
        F6_VMV: begin
          // vmv.v is a slide by zero, vm 0 would be vmerge
          part_o.req.op      = VSLIDEUP;
          part_o.req.ex_unit = SLD;
          part_o.req.vmv     = 1'b1;
          part_o.req.insert  = (funct3 == OPIVX) | (funct3 == OPIVI);
          part_o.req.vs2     = fld_vs1;
          op_bad             = ~vm;
        end
        default: op_bad = 1'b1;
      endcase

      // Operand source
      unique case (funct3)
        OPIVV: begin
          part_o.req.vs1     = fld_vs1;
          part_o.req.use_vs1 = 1'b1;
        end
        OPIVX: begin
          part_o.req.rs1 = req_i.rs1;
          opnd_bad       = ~req_i.rs1_valid;
        end
        OPIVI: part_o.req.rs1 = imm_zext ? elen_t'(fld_vs1) : elen_t'($signed(fld_vs1));
        default: opnd_bad = 1'b1;
      endcase

      part_o.illegal = op_bad | opnd_bad;
    end
  end

endmodule : vdec_arith_decode

`default_nettype wire

// File: logic/vdec_cfg_decode.sv
/* vsetvli, vsetivli and vsetvl. vtype is passed on unchecked,
   vill is left for the controller to set */
`default_nettype none

module vdec_cfg_decode (
  input  vdec_pkg::vdec_req_t  req_i,
  output vdec_pkg::vdec_part_t part_o
);

  import vdec_pkg::*;
  import rvv_isa_pkg::*;

  logic       hit;
  logic [4:0] fld_rs1;
  logic [4:0] fld_rd;

  assign hit     = (req_i.instr[6:0] == OPC_OP_V) & (req_i.instr[14:12] == OPCFG);
  assign fld_rs1 = req_i.instr[19:15];
  assign fld_rd  = req_i.instr[11:7];

  always_comb begin
    part_o = '0;
    if (hit) begin
      part_o.hit         = 1'b1;
      part_o.req.op      = VCFG;
      part_o.req.ex_unit = CON;
      part_o.req.rd      = fld_rd;
      part_o.req.use_rd  = 1'b1;

      if (!req_i.instr[31]) begin
        // vsetvli
        part_o.req.vtype = vtype_t'({1'b0, req_i.instr[27:20]});
        part_o.req.rs1   = req_i.rs1;
        part_o.illegal   = ~req_i.rs1_valid;
      end else if (req_i.instr[31:30] == 2'b11) begin
        // vsetivli, AVL is the uimm field
        part_o.req.vtype = vtype_t'({1'b0, req_i.instr[27:20]});
        part_o.req.rs1   = elen_t'(fld_rs1);
      end else if (req_i.instr[31:25] == 7'b1000000) begin
        part_o.req.vtype = vtype_t'({1'b0, req_i.rs2[7:0]});
        part_o.req.rs1   = req_i.rs1;
        part_o.illegal   = ~req_i.rs1_valid | ~req_i.rs2_valid;
      end else begin
        part_o.illegal = 1'b1;
      end

      // Request VLMAX
      if (fld_rs1 == '0 && fld_rd != '0) begin
        part_o.req.rs1 = '1;
      end
      part_o.req.keep_vl = (fld_rs1 == '0) && (fld_rd == '0);
    end
  end

endmodule : vdec_cfg_decode

`default_nettype wire

// File: logic/vector_decoder.sv
/* Fixed one-cycle latency, one request per cycle, no back-pressure.
   rsp_o is all zero in cycles without a request */
`default_nettype none

module vector_decoder (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Offloaded instruction
  input  vdec_pkg::vdec_req_t req_i,
  input  logic                req_valid_i,
  // Decoded request
  output vdec_pkg::vdec_rsp_t rsp_o,
  output logic                rsp_valid_o
);

  import vdec_pkg::*;

  vdec_part_t part_mem;
  vdec_part_t part_arith;
  vdec_part_t part_cfg;
  vdec_part_t part_all;
  logic       illegal;
  vdec_rsp_t  rsp_d;

  //////////////////////////////////////////////////
  // Sub-decoders
  //////////////////////////////////////////////////

  vdec_mem_decode i_mem_decode (
    .req_i  (req_i),
    .part_o (part_mem)
  );

  vdec_arith_decode i_arith_decode (
    .req_i  (req_i),
    .part_o (part_arith)
  );

  vdec_cfg_decode i_cfg_decode (
    .req_i  (req_i),
    .part_o (part_cfg)
  );

  // Groups are disjoint, so an OR picks the one hit
  assign part_all = vdec_part_t'(part_mem | part_arith | part_cfg);
  assign illegal  = part_all.illegal | ~part_all.hit;

  always_comb begin
    rsp_d = '0;
    if (req_valid_i) begin
      rsp_d.req              = part_all.req;
      rsp_d.req.reset_vstart = ~illegal;
      rsp_d.req.xintf_id     = req_i.xintf_id;
      rsp_d.illegal          = illegal;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_o       <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_o       <= rsp_d;
      rsp_valid_o <= req_valid_i;
    end
  end

endmodule : vector_decoder

`default_nettype wire

// File: sim/vector_decoder_checker.sv
/* Reference decode bound to vector_decoder. In an illegal response only
   illegal, reset_vstart and xintf_id are compared */
`default_nettype none

module vector_decoder_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input vdec_pkg::vdec_req_t req_i,
  input logic                req_valid_i,
  input vdec_pkg::vdec_rsp_t rsp_o,
  input logic                rsp_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import vdec_pkg::*;
  import rvv_isa_pkg::*;

  vdec_req_t req_q;
  logic      valid_q;
  vdec_rsp_t exp_rsp;
  int        err_count = 0;
  int        rsp_count;

  function automatic vdec_rsp_t predict_rsp(vdec_req_t r);
    vdec_rsp_t   p;
    logic [31:0] i;
    logic [2:0]  f3;
    logic [4:0]  f_rs1;
    logic [4:0]  f_rd;
    logic        zext;
    logic        bad;
    p     = '0;
    i     = r.instr;
    f3    = i[14:12];
    f_rs1 = i[19:15];
    f_rd  = i[11:7];
    zext  = 1'b0;
    bad   = 1'b0;
    if (i[6:0] == OPC_LOAD_FP || i[6:0] == OPC_STORE_FP) begin
      p.req.ex_unit   = LSU;
      p.req.vd        = f_rd;
      p.req.use_vd    = 1'b1;
      p.req.vm        = i[25];
      p.req.is_load   = (i[6:0] == OPC_LOAD_FP);
      p.req.vd_is_src = ~p.req.is_load;
      p.req.rs1       = r.rs1;
      bad             = ~r.rs1_valid;
      case ({i[28], f3})
        4'b0000: p.req.vtype.vsew = EW_8;
        4'b0101: p.req.vtype.vsew = EW_16;
        4'b0110: p.req.vtype.vsew = EW_32;
        default: bad = 1'b1;
      endcase
      if (i[27:26] == MOP_UNIT) begin
        p.req.op = p.req.is_load ? VLE : VSE;
      end else if (i[27:26] == MOP_STRIDED) begin
        p.req.op  = p.req.is_load ? VLSE : VSSE;
        p.req.rs2 = r.rs2;
        bad       = bad | ~r.rs2_valid;
      end else begin
        bad = 1'b1;
      end
    end else if (i[6:0] == OPC_OP_V && f3 == OPCFG) begin
      p.req.op      = VCFG;
      p.req.ex_unit = CON;
      p.req.rd      = f_rd;
      p.req.use_rd  = 1'b1;
      p.req.rs1     = r.rs1;
      p.req.vtype   = vtype_t'({1'b0, i[27:20]});
      if (i[31] == 1'b0) begin
        bad = ~r.rs1_valid;
      end else if (i[31:30] == 2'b11) begin
        p.req.rs1 = {27'd0, f_rs1};
      end else if (i[31:25] == 7'b1000000) begin
        p.req.vtype = vtype_t'({1'b0, r.rs2[7:0]});
        bad         = ~(r.rs1_valid & r.rs2_valid);
      end else begin
        bad = 1'b1;
      end
      if (f_rs1 == 5'd0 && f_rd != 5'd0) p.req.rs1 = '1;
      p.req.keep_vl = (f_rs1 == 5'd0) && (f_rd == 5'd0);
    end else if (i[6:0] == OPC_OP_V) begin
      p.req.ex_unit = VFU;
      p.req.vd      = f_rd;
      p.req.use_vd  = 1'b1;
      p.req.vs2     = i[24:20];
      p.req.use_vs2 = 1'b1;
      p.req.vm      = i[25];
      case (i[31:26])
        F6_VADD:  p.req.op = VADD;
        F6_VSUB:  p.req.op = VSUB;
        F6_VRSUB: p.req.op = VRSUB;
        F6_VAND:  p.req.op = VAND;
        F6_VOR:   p.req.op = VOR;
        F6_VXOR:  p.req.op = VXOR;
        F6_VSLL:  p.req.op = VSLL;
        F6_VSRL:  p.req.op = VSRL;
        F6_VSRA:  p.req.op = VSRA;
        F6_VSLIDEUP:   p.req.op = VSLIDEUP;
        F6_VSLIDEDOWN: p.req.op = VSLIDEDOWN;
        F6_VMV: begin
          p.req.op     = VSLIDEUP;
          p.req.vmv    = 1'b1;
          p.req.insert = (f3 != OPIVV);
          p.req.vs2    = f_rs1;
          bad          = ~i[25];
        end
        default: bad = 1'b1;
      endcase
      if (p.req.op inside {VSLIDEUP, VSLIDEDOWN}) p.req.ex_unit = SLD;
      zext = p.req.op inside {VSLL, VSRL, VSRA} || (p.req.ex_unit == SLD && !p.req.vmv);
      // Excluded form combinations
      if (p.req.op == VSUB && f3 == OPIVI) bad = 1'b1;
      if (p.req.op == VRSUB && f3 == OPIVV) bad = 1'b1;
      if (p.req.ex_unit == SLD && !p.req.vmv && f3 == OPIVV) bad = 1'b1;
      case (f3)
        OPIVV: begin
          p.req.vs1     = f_rs1;
          p.req.use_vs1 = 1'b1;
        end
        OPIVX: begin
          p.req.rs1 = r.rs1;
          bad       = bad | ~r.rs1_valid;
        end
        OPIVI: p.req.rs1 = zext ? {27'd0, f_rs1} : {{27{f_rs1[4]}}, f_rs1};
        default: bad = 1'b1;
      endcase
    end else begin
      bad = 1'b1;
    end
    p.illegal          = bad;
    p.req.reset_vstart = ~bad;
    p.req.xintf_id     = r.xintf_id;
    return p;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q     <= '0;
      valid_q   <= 1'b0;
      rsp_count <= 0;
    end else begin
      req_q   <= req_i;
      valid_q <= req_valid_i;
      if (rsp_valid_o) rsp_count <= rsp_count + 1;
    end
  end

  always_comb exp_rsp = predict_rsp(req_q);

  //////////////////////////////////////////////////
  // Response checks
  //////////////////////////////////////////////////

  a_rsp_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o == valid_q)
    else begin
      err_count++;
      $error("MISMATCH %0t rsp_valid_o expected %0b actual %0b", $time,
             $sampled(valid_q), $sampled(rsp_valid_o));
    end

  a_idle_zero : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !valid_q |-> rsp_o == '0)
    else begin
      err_count++;
      $error("MISMATCH %0t rsp_o expected 0 actual %h", $time, $sampled(rsp_o));
    end

  a_illegal : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_q |-> rsp_o.illegal == exp_rsp.illegal)
    else begin
      err_count++;
      $error("MISMATCH %0t rsp_o.illegal expected %0b actual %0b (instr %h)", $time,
             $sampled(exp_rsp.illegal), $sampled(rsp_o.illegal), $sampled(req_q.instr));
    end

  a_reset_vstart : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_q |-> rsp_o.req.reset_vstart == exp_rsp.req.reset_vstart)
    else begin
      err_count++;
      $error("MISMATCH %0t rsp_o.req.reset_vstart expected %0b actual %0b", $time,
             $sampled(exp_rsp.req.reset_vstart), $sampled(rsp_o.req.reset_vstart));
    end

  a_xintf_id : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_q |-> rsp_o.req.xintf_id == req_q.xintf_id)
    else begin
      err_count++;
      $error("MISMATCH %0t rsp_o.req.xintf_id expected %h actual %h", $time,
             $sampled(req_q.xintf_id), $sampled(rsp_o.req.xintf_id));
    end

  a_req_fields : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_q && !exp_rsp.illegal |-> rsp_o.req == exp_rsp.req)
    else begin
      err_count++;
      $error("MISMATCH %0t rsp_o.req expected %h actual %h (instr %h)", $time,
             $sampled(exp_rsp.req), $sampled(rsp_o.req), $sampled(req_q.instr));
    end

endmodule : vector_decoder_checker

`default_nettype wire

// File: sim/vector_decoder_tb_clk.sv
/* 20 ns clock, reset held low for the first 5 rising edges */
`default_nettype none

module vector_decoder_tb_clk (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule : vector_decoder_tb_clk

`default_nettype wire

// File: sim/vector_decoder_tb.sv
/* Directed list of every kept form, then 400 LFSR instructions with idle
   gaps. Response checking sits in the bound checker */
`default_nettype none

module vector_decoder_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import vdec_pkg::*;
  import rvv_isa_pkg::*;

  localparam int RESET_CYCLES   = 5;
  localparam int DIRECTED_COUNT = 58;
  localparam int RANDOM_COUNT   = 400;
  localparam int MAX_CYCLES     = RESET_CYCLES + DIRECTED_COUNT + RANDOM_COUNT * 2 + 50;

  logic        clk;
  logic        rst_n;
  vdec_req_t   req;
  logic        req_valid;
  vdec_rsp_t   rsp;
  logic        rsp_valid;
  logic [31:0] lfsr;
  logic [3:0]  id_q;
  int          sent;
  int          errors;
  int          cycles = 0;

  vector_decoder_tb_clk i_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  vector_decoder i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid)
  );

  bind vector_decoder vector_decoder_checker i_checker (.*);

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [5:0] f6_at(logic [3:0] k);
    case (k)
      4'd0:    return F6_VADD;
      4'd1:    return F6_VSUB;
      4'd2:    return F6_VRSUB;
      4'd3:    return F6_VAND;
      4'd4:    return F6_VOR;
      4'd5:    return F6_VXOR;
      4'd6:    return F6_VSLL;
      4'd7:    return F6_VSRL;
      4'd8:    return F6_VSRA;
      4'd9:    return F6_VSLIDEUP;
      4'd10:   return F6_VSLIDEDOWN;
      4'd11:   return F6_VMV;
      default: return 6'b111111;
    endcase
  endfunction

  function automatic logic [2:0] width_at(logic [1:0] k);
    case (k)
      2'd0:    return 3'b000;
      2'd1:    return 3'b101;
      default: return 3'b110;
    endcase
  endfunction

  function automatic logic [31:0] enc_mem(logic store, logic mew, logic [1:0] mop,
                                          logic [2:0] width, logic [4:0] vd);
    return {3'b000, mew, mop, 1'b1, 5'd2, 5'd3, width, vd,
            store ? OPC_STORE_FP : OPC_LOAD_FP};
  endfunction

  function automatic logic [31:0] enc_opv(logic [5:0] f6, logic vm, logic [2:0] f3);
    return {f6, vm, 5'd5, 5'd22, f3, 5'd4, OPC_OP_V};
  endfunction

  function automatic logic [31:0] enc_cfg(logic [11:0] hi, logic [4:0] f_rs1, logic [4:0] rd);
    return {hi, f_rs1, 3'b111, rd, OPC_OP_V};
  endfunction

  task automatic send(logic [31:0] instr, elen_t rs1, logic rs1_v, elen_t rs2, logic rs2_v);
    @(negedge clk);
    req.instr     = instr;
    req.rs1       = rs1;
    req.rs1_valid = rs1_v;
    req.rs2       = rs2;
    req.rs2_valid = rs2_v;
    req.xintf_id  = id_q;
    req_valid     = 1'b1;
    id_q          = id_q + 1'b1;
    sent++;
  endtask

  task automatic idle();
    @(negedge clk);
    req       = '0;
    req_valid = 1'b0;
  endtask

  task automatic run_directed();
    for (int s = 0; s < 2; s++) begin
      for (int w = 0; w < 3; w++) begin
        send(enc_mem(s == 1, 1'b0, MOP_UNIT, width_at(w[1:0]), 5'd4), 32'h1000, 1, 32'h40, 1);
        send(enc_mem(s == 1, 1'b0, MOP_STRIDED, width_at(w[1:0]), 5'd4), 32'h1000, 1, 32'h40, 1);
      end
    end
    // Bad width code followed by bad mop
    send(enc_mem(1'b0, 1'b1, MOP_UNIT, 3'b000, 5'd4), 32'h1000, 1, 32'h40, 1);
    send(enc_mem(1'b0, 1'b0, 2'b01, 3'b000, 5'd4), 32'h1000, 1, 32'h40, 1);
    for (int k = 0; k < 12; k++) begin
      send(enc_opv(f6_at(k[3:0]), 1'b1, OPIVV), 32'h7, 1, 32'h0, 1);
      send(enc_opv(f6_at(k[3:0]), 1'b1, OPIVX), 32'h7, 1, 32'h0, 1);
      send(enc_opv(f6_at(k[3:0]), 1'b1, OPIVI), 32'h7, 1, 32'h0, 1);
    end
    send(enc_opv(F6_VMV, 1'b0, OPIVV), 32'h7, 1, 32'h0, 1);
    send(enc_cfg({1'b0, 11'h0d1}, 5'd3, 5'd4), 32'h20, 1, 32'h0, 1);
    send(enc_cfg({2'b11, 10'h0d1}, 5'd9, 5'd4), 32'h20, 1, 32'h0, 1);
    send(enc_cfg({7'b1000000, 5'd6}, 5'd3, 5'd4), 32'h20, 1, 32'hd1, 1);
    send(enc_cfg({1'b0, 11'h0d1}, 5'd0, 5'd4), 32'h20, 1, 32'h0, 1);
    send(enc_cfg({7'b1000000, 5'd6}, 5'd0, 5'd0), 32'h20, 1, 32'hd1, 1);
    send(enc_cfg({7'b1000001, 5'd6}, 5'd3, 5'd4), 32'h20, 1, 32'hd1, 1);
    send(32'h0000_0033, 32'h0, 1, 32'h0, 1);
  endtask

  task automatic run_random();
    logic [1:0]  cls;
    logic [3:0]  idx;
    logic [31:0] instr;
    elen_t       a;
    elen_t       b;
    logic        v1;
    logic        v2;
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      cls   = 2'(rand_bits(2));
      idx   = 4'(rand_bits(4));
      instr = rand_bits(32);
      case (cls)
        2'd0: begin
          instr[6:0]   = instr[31] ? OPC_STORE_FP : OPC_LOAD_FP;
          instr[31:29] = 3'b000;
          if (idx[1:0] != 2'd3) begin
            instr[28]    = 1'b0;
            instr[14:12] = width_at(idx[1:0]);
          end
        end
        2'd1: begin
          instr[6:0] = OPC_OP_V;
          if (idx < 4'd12) instr[31:26] = f6_at(idx);
          case (instr[13:12])
            2'd0:    instr[14:12] = OPIVV;
            2'd1:    instr[14:12] = OPIVX;
            2'd2:    instr[14:12] = OPIVI;
            default: ;
          endcase
        end
        2'd2: begin
          instr[6:0]   = OPC_OP_V;
          instr[14:12] = OPCFG;
          case (idx[1:0])
            2'd0:    instr[31] = 1'b0;
            2'd1:    instr[31:30] = 2'b11;
            2'd2:    instr[31:25] = 7'b1000000;
            default: ;
          endcase
          if (idx[3:2] == 2'd0) instr[19:15] = 5'd0;
          if (rand_bits(2) == 0) instr[11:7] = 5'd0;
        end
        default: ;
      endcase
      a  = rand_bits(32);
      b  = rand_bits(32);
      v1 = (rand_bits(3) != 0);
      v2 = (rand_bits(3) != 0);
      send(instr, a, v1, b, v2);
      if (rand_bits(1) != 0) idle();
    end
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run not finished after %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    lfsr      = 32'hcc45bfaa;
    req       = '0;
    req_valid = 1'b0;
    id_q      = '0;
    sent      = 0;
    @(posedge rst_n);
    run_directed();
    run_random();
    idle();
    idle();
    @(posedge clk);
    @(negedge clk);
    errors = i_dut.i_checker.err_count;
    if (i_dut.i_checker.rsp_count != sent) begin
      $display("MISMATCH %0t rsp_valid_o count expected %0d actual %0d",
               $time, sent, i_dut.i_checker.rsp_count);
      errors++;
    end
    $display("Requests %0d, responses %0d, assertion errors %0d, total errors %0d",
             sent, i_dut.i_checker.rsp_count, i_dut.i_checker.err_count, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : vector_decoder_tb

`default_nettype wire

// File: vector_decoder.f
logic/rvv_isa_pkg.sv
logic/vdec_pkg.sv
logic/vdec_mem_decode.sv
logic/vdec_arith_decode.sv
logic/vdec_cfg_decode.sv
logic/vector_decoder.sv
sim/vector_decoder_checker.sv
sim/vector_decoder_tb_clk.sv
sim/vector_decoder_tb.sv
